// ==== bench/mac_mouse_cases.txt ====
# kind dev0 dev1 dev2 dev3 host_byte host_frames x_steps y_steps button
# packet sends dev0..dev2, skip sends dev0 as a stray byte then dev1..dev3
bad    55 00 00 00 ff 1    0    0 1
badid  aa 33 00 00 ff 1    0    0 1
silent 00 00 00 00 ff 1    0    0 1
init   aa 00 fa 00 f4 1    0    0 1
packet 09 05 03 00 00 0    5    3 0
packet 38 fb fe 00 00 0   -5   -2 1
packet 08 ff 01 00 00 0  255    1 1
packet 39 00 00 00 00 0 -256 -256 0
skip   02 29 0a f6 00 0   10  -10 0
random 00 00 00 00 00 0    0    0 1
random 00 00 00 00 00 0    0    0 1
random 00 00 00 00 00 0    0    0 1
random 00 00 00 00 00 0    0    0 1

// ==== vlog.f ====
source/ps2_link_pkg.sv
source/mouse_pkg.sv
source/ps2_link.sv
source/ps2_mouse.sv
source/quadrature_axis.sv
source/mac_mouse_top.sv
bench/mac_mouse_checker.sv
bench/mac_mouse_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mouse testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mac_mouse_tb \
	-f vlog.f -o mac_mouse_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/mac_mouse_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1

// ==== bench/mac_mouse_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_mouse_tb;
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int TICK_BITS = 4;
	localparam int HALF_BIT = 20;                                  // Half a device clock period in sysclk cycles
	localparam int FRAME_CYCLES = 24 * HALF_BIT;                   // One frame with some slack
	localparam int REPLY_LIMIT = TIMEOUT_CYCLES / 8 + FRAME_CYCLES; // Inhibit plus a frame
	localparam int CASE_CYCLES = 2 * TIMEOUT_CYCLES + 6 * FRAME_CYCLES + 260 * (2 ** TICK_BITS);

	logic sysclk, reset, clk_en, ps2clk_in, ps2dat_in;
	logic dev_clk, dev_dat;                   // Device side of the open-drain lines
	wire ps2clk_low, ps2dat_low, x1, x2, y1, y2, button;
	logic test_start, test_end, host_strobe, exp_button, check_move;
	logic [7:0] host_byte, exp_host;
	int exp_x, exp_y, exp_frames, chk_errors, chk_tests;
	int tb_errors = 0;
	int cycle = 0;
	int cycle_limit = 0;                      // Set once the cases are known
	logic [31:0] lfsr = 32'h6b8eaf63;
	string kind_q[$];                         // Case lines without the comments

	mac_mouse_top #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES), .TICK_BITS(TICK_BITS)) mac_mouse_top_i (
		.sysclk, .reset, .clk_en, .ps2clk_in, .ps2dat_in, .ps2clk_low, .ps2dat_low,
		.x1, .x2, .y1, .y2, .button);

	mac_mouse_checker checker_i (.sysclk, .x1, .x2, .y1, .y2, .button, .ps2clk_low,
		.test_start, .test_end, .check_move, .host_strobe, .host_byte, .exp_host,
		.exp_button, .exp_x, .exp_y, .exp_frames, .errors(chk_errors), .tests(chk_tests));

	initial begin
		sysclk = 1'b0;
		forever #20 sysclk = ~sysclk;
	end

	always @(negedge sysclk) begin
		ps2clk_in <= dev_clk & ~ps2clk_low; // Wired AND of device and host
		ps2dat_in <= dev_dat & ~ps2dat_low;
	end

	always @(posedge sysclk) begin
		cycle <= cycle + 1;
		if (cycle_limit > 0 && cycle >= cycle_limit) begin
			$display("Run stopped after %0d cycles before all cases finished", cycle);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1); // Galois form, taps 32 30 26 25
	endfunction

	task automatic take_bits(input int n, output logic [8:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[7:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic cycles(input int n);
		repeat (n) @(negedge sysclk);
	endtask

	task automatic apply_reset();
		reset <= 1'b1;
		cycles(16);
		reset <= 1'b0;
		cycles(4);
	endtask

	task automatic device_send(input logic [7:0] b);
		logic [10:0] frame;
		frame = {1'b1, ~^b, b, 1'b0}; // Stop, odd parity, data, start
		for (int i = 0; i < 11; i++) begin
			dev_dat <= frame[i];
			cycles(HALF_BIT / 2);
			dev_clk <= 1'b0;
			cycles(HALF_BIT);
			dev_clk <= 1'b1;
			cycles(HALF_BIT / 2);
		end
		cycles(HALF_BIT);
	endtask

	task automatic host_receive(input int limit);
		logic [9:0] bits;
		int waited;
		waited = 0;
		while (!(ps2dat_low && !ps2clk_low) && waited < limit) begin // Request to send
			cycles(1);
			waited++;
		end
		if (waited >= limit) begin
			$display("No host frame started within %0d cycles at %0t ns", limit, $time);
			tb_errors++;
		end else begin
			cycles(HALF_BIT);
			for (int i = 0; i < 11; i++) begin
				if (i == 10)
					dev_dat <= 1'b0; // Acknowledge bit
				cycles(HALF_BIT / 2);
				dev_clk <= 1'b0;
				cycles(HALF_BIT);
				dev_clk <= 1'b1;
				cycles(HALF_BIT / 2);
				if (i < 10)
					bits[i] = ~ps2dat_low; // Read while the clock is high
			end
			dev_dat <= 1'b1;
			if (!bits[9] || !(^bits[8:0])) begin
				$display("Host frame ending at %0t ns has a bad parity or stop bit", $time);
				tb_errors++;
			end
			host_byte <= bits[7:0];
			host_strobe <= 1'b1;
			cycles(1);
			host_strobe <= 1'b0;
		end
	endtask

	task automatic wait_quiet();
		int still;
		logic px, py;
		still = 0;
		px = x1;
		py = y1;
		while (still < 2 ** (TICK_BITS + 1)) begin
			cycles(1);
			still = (x1 != px || y1 != py) ? 0 : still + 1;
			px = x1;
			py = y1;
		end
	endtask

	initial begin
		string line, kind;
		int fd, host_v, frames_v, x_v, y_v, btn_v;
		logic [7:0] b0, b1, b2, b3;
		logic [8:0] r, rx, ry;
		reset = 1'b1;
		clk_en = 1'b1;
		ps2clk_in = 1'b1;
		ps2dat_in = 1'b1;
		dev_clk = 1'b1;
		dev_dat = 1'b1;
		{test_start, test_end, host_strobe, exp_button, check_move} = '0;
		{host_byte, exp_host, exp_x, exp_y, exp_frames} = '0;
		fd = $fopen("bench/mac_mouse_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the cases file bench/mac_mouse_cases.txt");
			tb_errors++;
		end else begin
			while ($fgets(line, fd) > 0)
				if (line.len() > 1 && line.getc(0) != "#")
					kind_q.push_back(line);
			$fclose(fd);
		end
		cycle_limit = (kind_q.size() + 1) * CASE_CYCLES;
		apply_reset();
		foreach (kind_q[n]) begin
			void'($sscanf(kind_q[n], "%s %h %h %h %h %h %d %d %d %d", kind, b0, b1, b2, b3,
				host_v, frames_v, x_v, y_v, btn_v));
			if (kind == "random") begin
				take_bits(1, r);
				take_bits(9, rx);
				take_bits(9, ry);
				b0 = {2'b00, ry[8], rx[8], 1'b1, 2'b00, r[0]}; // Status byte with bit 3 set
				b1 = rx[7:0];
				b2 = ry[7:0];
				x_v = int'($signed(rx));
				y_v = int'($signed(ry));
				btn_v = {31'b0, ~r[0]};                       // Button line is low while pressed
				frames_v = 0;
			end
			exp_x <= x_v;
			exp_y <= y_v;
			exp_button <= btn_v[0];
			exp_host <= host_v[7:0];
			exp_frames <= frames_v;
			check_move <= kind == "packet" || kind == "skip" || kind == "random";
			if (kind == "bad" || kind == "badid" || kind == "silent" || kind == "init")
				apply_reset();
			test_start <= 1'b1;
			cycles(1);
			test_start <= 1'b0;
			if (kind == "silent") begin
				host_receive(TIMEOUT_CYCLES + REPLY_LIMIT);
			end else if (kind == "bad") begin
				device_send(b0);
				host_receive(REPLY_LIMIT);
			end else if (kind == "badid" || kind == "init") begin
				device_send(b0);
				device_send(b1);
				host_receive(REPLY_LIMIT);
				if (kind == "init") begin
					device_send(b2);
					cycles(TIMEOUT_CYCLES + FRAME_CYCLES); // A second host frame would land here
				end
			end else begin
				if (kind == "skip") begin
					device_send(b0); // Stray byte with bit 3 clear
					b0 = b1;
					b1 = b2;
					b2 = b3;
				end
				device_send(b0);
				device_send(b1);
				device_send(b2);
				wait_quiet();
			end
			test_end <= 1'b1;
			cycles(1);
			test_end <= 1'b0;
			cycles(2);
		end
		cycles(4);
		$display("Cases %0d, tests checked %0d, errors %0d", kind_q.size(), chk_tests,
			chk_errors + tb_errors);
		if (chk_errors + tb_errors == 0 && chk_tests == kind_q.size() && kind_q.size() > 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/mac_mouse_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_mouse_checker (
	input  wire       sysclk,
	input  wire       x1,
	input  wire       x2,
	input  wire       y1,
	input  wire       y2,
	input  wire       button,
	input  wire       ps2clk_low,
	input  wire       test_start,  // Clears the per-test counts
	input  wire       test_end,    // Compares and prints the test line
	input  wire       check_move,  // Steps and button are checked in packet tests only
	input  wire       host_strobe,
	input  wire [7:0] host_byte,
	input  wire [7:0] exp_host,
	input  wire       exp_button,
	input  int        exp_x,
	input  int        exp_y,
	input  int        exp_frames,
	output int        errors,
	output int        tests
);
	int x_steps, y_steps, frames, test_errors, button_changes;
	logic x1_prev, y1_prev, clk_low_prev, button_prev;
	logic x2_want, y2_want; // Phase that the direction of motion asks for

	initial begin
		errors = 0;
		tests = 0;
		{x_steps, y_steps, frames, test_errors, button_changes} = '0;
		{x1_prev, y1_prev, clk_low_prev} = '0;
		button_prev = 1'b1; // Released after reset
		{x2_want, y2_want} = '0;
	end

	function automatic int magnitude(input int v);
		return v < 0 ? -v : v;
	endfunction

	task automatic report_value(input string name, input int got, input int want);
		$display("ERROR at %0t ns: %s got %0d expected %0d", $time, name, got, want);
		test_errors++;
	endtask

	always @(posedge sysclk) begin
		x2_want = exp_x > 0 ? ~x1 : x1; // Positive motion puts x2 opposite x1
		y2_want = exp_y > 0 ? ~y1 : y1;
		if (test_start) begin
			{x_steps, y_steps, frames, test_errors, button_changes} = '0;
		end else begin
			if (x1 != x1_prev) begin
				x_steps++;
				if (x2 != x2_want)
					report_value("x2", x2, x2_want);
			end
			if (y1 != y1_prev) begin
				y_steps++;
				if (y2 != y2_want)
					report_value("y2", y2, y2_want);
			end
			if (button != button_prev)
				button_changes++; // Only an aligned status byte may move it
			if (ps2clk_low && !clk_low_prev)
				frames++; // Each host send starts by pulling the clock low
			if (host_strobe && host_byte != exp_host) begin
				$display("ERROR at %0t ns: host byte got %h expected %h", $time, host_byte, exp_host);
				test_errors++;
			end
			if (test_end) begin
				if (frames != exp_frames)
					report_value("host frames", frames, exp_frames);
				if (check_move) begin
					if (x_steps != magnitude(exp_x))
						report_value("x1 toggles", x_steps, magnitude(exp_x));
					if (y_steps != magnitude(exp_y))
						report_value("y1 toggles", y_steps, magnitude(exp_y));
					if (button != exp_button)
						report_value("button", button, exp_button);
					if (button_changes > 1) begin
						$display("ERROR at %0t ns: button changed %0d times within one packet",
							$time, button_changes);
						test_errors++;
					end
				end
				tests++;
				errors += test_errors;
				$display("Test %0d %s with %0d errors", tests, test_errors != 0 ? "failed" : "ok",
					test_errors);
			end
		end
		x1_prev = x1;
		y1_prev = y1;
		clk_low_prev = ps2clk_low;
		button_prev = button;
	end

endmodule

`default_nettype wire

// ==== source/mac_mouse_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_mouse_top #(
	parameter int TIMEOUT_CYCLES = 16000,
	parameter int TICK_BITS = 12,
	parameter int ACC_BITS = 10
) (
	input  wire sysclk,
	input  wire reset,
	input  wire clk_en,
	input  wire ps2clk_in,
	input  wire ps2dat_in,
	output wire ps2clk_low,
	output wire ps2dat_low,
	output wire x1,
	output wire x2,
	output wire y1,
	output wire y2,
	output wire button
);
	import ps2_link_pkg::*;
	import mouse_pkg::*;

	ps2_rx_t    rx;          // Received bytes from the link
	ps2_tx_t    tx;          // Commands back to the link
	logic       timeout;     // No reply while initializing
	logic       timeout_arm;
	axis_move_t x_move;
	axis_move_t y_move;
	logic       tick;        // Shared flush tick for both axes

	ps2_link #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) ps2_link_i (.sysclk, .reset, .clk_en,
		.ps2clk_in, .ps2dat_in, .ps2clk_low, .ps2dat_low, .tx, .rx, .timeout, .timeout_arm);

	ps2_mouse #(.TICK_BITS(TICK_BITS)) ps2_mouse_i (.sysclk, .reset, .clk_en,
		.rx, .timeout, .tx, .timeout_arm, .x_move, .y_move, .tick, .button);

	quadrature_axis #(.ACC_BITS(ACC_BITS)) x_axis_i (.sysclk, .reset, .clk_en,
		.move(x_move), .tick, .q1(x1), .q2(x2));

	quadrature_axis #(.ACC_BITS(ACC_BITS)) y_axis_i (.sysclk, .reset, .clk_en,
		.move(y_move), .tick, .q1(y1), .q2(y2));

endmodule

`default_nettype wire

// ==== source/quadrature_axis.sv ====
`timescale 1ns/1ps
`default_nettype none

module quadrature_axis #(
	parameter int ACC_BITS = 10
) (
	input  wire                        sysclk,
	input  wire                        reset,
	input  wire                        clk_en,
	input  wire mouse_pkg::axis_move_t move,
	input  wire                        tick,
	output logic                       q1,
	output logic                       q2
);
	logic [ACC_BITS-1:0] acc;       // Signed count of steps still to emit
	logic [ACC_BITS:0]   load_sum;  // One extra bit to see the true sum
	logic                saturated; // Top two bits differ so another delta could wrap

	assign saturated = acc[ACC_BITS-1] != acc[ACC_BITS-2];
	assign load_sum = {acc[ACC_BITS-1], acc} + {{(ACC_BITS-7){move.sign}}, move.delta};

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			acc <= '0;
			q1 <= 1'b0;
			q2 <= 1'b0;
		end else if (clk_en) begin
			if (move.load && !saturated) begin
				acc <= load_sum[ACC_BITS-1:0]; // A load takes the cycle and the tick waits
			end else if (tick && acc != '0) begin
				acc <= acc + {{(ACC_BITS-1){~acc[ACC_BITS-1]}}, 1'b1}; // One step toward zero
				q1 <= ~q1;
				q2 <= q1 ^ acc[ACC_BITS-1]; // Positive leaves q2 opposite the new q1
			end
		end
	end

	// An absorbed delta always fits, so the count stays within two to the ACC_BITS-1
	a_load_fits: assert property (@(posedge sysclk) disable iff (reset)
		clk_en && move.load && !saturated |-> load_sum[ACC_BITS] == load_sum[ACC_BITS-1]);

endmodule

`default_nettype wire

// ==== source/ps2_mouse.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_mouse #(
	parameter int TICK_BITS = 12
) (
	input  wire                    sysclk,
	input  wire                    reset,
	input  wire                    clk_en,
	input  wire ps2_link_pkg::ps2_rx_t rx,
	input  wire                    timeout,
	output ps2_link_pkg::ps2_tx_t  tx,
	output logic                   timeout_arm,
	output mouse_pkg::axis_move_t  x_move,
	output mouse_pkg::axis_move_t  y_move,
	output logic                   tick,
	output logic                   button
);
	import ps2_link_pkg::*;
	import mouse_pkg::*;

	mouse_state_e         state;
	mouse_state_e         next;
	logic                 send_req;  // Send a byte in the next cycle
	logic [7:0]           send_byte;
	mouse_status_t        status;    // Received byte viewed as a packet status byte
	logic                 x_sign;    // Signs latched from byte 0
	logic                 y_sign;
	logic [TICK_BITS-1:0] tick_div;  // Free-running flush divider

	assign status = rx.data;
	assign timeout_arm = (state == init) || (state == id) || (state == setup); // Only the init phase expects replies

	always_comb begin
		next = state;
		send_req = 1'b0;
		send_byte = CMD_RESET; // Every recovery path resends the reset
		if (timeout) begin
			next = init;
			send_req = 1'b1;
		end else if (rx.strobe) begin
			case (state)
				init: begin
					if (rx.data == REPLY_BAT_OK)
						next = id;
					else if (rx.data != REPLY_ACK)
						send_req = 1'b1; // Acknowledge of our own reset is expected and skipped
				end
				id: begin
					send_req = 1'b1;
					if (rx.data == DEVICE_ID_MOUSE) begin
						send_byte = CMD_ENABLE;
						next = setup;
					end else begin
						next = init;
					end
				end
				setup: begin
					if (rx.data == REPLY_ACK) begin
						next = byte0;
					end else begin
						send_req = 1'b1;
						next = init;
					end
				end
				byte0: if (status.always_one) next = byte1; // Otherwise stay and resynchronize
				byte1: next = byte2;
				byte2: next = byte0;
				default: next = init;
			endcase
		end
	end

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			state <= init;
			tx <= '0;
			x_move <= '0;
			y_move <= '0;
			x_sign <= 1'b0;
			y_sign <= 1'b0;
			button <= 1'b1; // Released
			tick_div <= '0;
			tick <= 1'b0;
		end else if (clk_en) begin
			state <= next;
			tx.req <= send_req; // Registered so a send never overlaps the receive that caused it
			tx.data <= send_byte;
			if (rx.strobe && state == byte0 && status.always_one) begin
				button <= ~status.left; // Host button line is active low
				x_sign <= status.x_sign;
				y_sign <= status.y_sign;
			end
			x_move.load <= rx.strobe && state == byte1;
			x_move.sign <= x_sign;
			x_move.delta <= rx.data;
			y_move.load <= rx.strobe && state == byte2;
			y_move.sign <= y_sign;
			y_move.delta <= rx.data;
			tick_div <= tick_div + 1'b1;
			tick <= &tick_div; // One pulse per divider wrap
		end
	end

	// Loads are registered a cycle after their byte so the state has already advanced
	a_x_load_from_packet: assert property (@(posedge sysclk) disable iff (reset)
		x_move.load |-> state == byte2);
	a_y_load_from_packet: assert property (@(posedge sysclk) disable iff (reset)
		y_move.load |-> state == byte0);

endmodule

`default_nettype wire

// ==== source/ps2_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_link #(
	parameter int TIMEOUT_CYCLES = 16000
) (
	input  wire                    sysclk,
	input  wire                    reset,
	input  wire                    clk_en,
	input  wire                    ps2clk_in,
	input  wire                    ps2dat_in,
	output logic                   ps2clk_low,
	output logic                   ps2dat_low,
	input  wire ps2_link_pkg::ps2_tx_t tx,
	output ps2_link_pkg::ps2_rx_t  rx,
	output logic                   timeout,
	input  wire                    timeout_arm
);
	import ps2_link_pkg::*;

	localparam int INHIBIT_CYCLES = TIMEOUT_CYCLES / 8; // Roughly 100 us of clock inhibit
	localparam int TIMER_BITS = $clog2(TIMEOUT_CYCLES + 1);

	link_state_e           state;
	logic [1:0]            clk_sync;  // Two-stage synchronizer for the device clock
	logic [1:0]            dat_sync;  // Two-stage synchronizer for the data line
	logic                  clk_prev;  // Last synchronized clock level
	logic                  fall;      // Falling edge of the device clock
	logic                  frame_ok;  // Start, parity and stop all correct
	logic [10:0]           rx_shift;  // Start bit ends up in bit 0 and stop bit in bit 10
	logic [9:0]            tx_shift;  // Data, parity and stop still to be presented
	logic [3:0]            bit_cnt;
	logic [TIMER_BITS-1:0] timer;     // Reply timeout in idle and inhibit length otherwise

	assign fall = clk_prev & ~clk_sync[1];
	assign frame_ok = ~rx_shift[0] & rx_shift[10] & (^rx_shift[9:1]); // Odd parity over data and parity

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			clk_sync <= 2'b11; // Both lines float high when nobody drives them
			dat_sync <= 2'b11;
			clk_prev <= 1'b1;
		end else if (clk_en) begin
			clk_sync <= {clk_sync[0], ps2clk_in};
			dat_sync <= {dat_sync[0], ps2dat_in};
			clk_prev <= clk_sync[1];
		end
	end

	always_ff @(posedge sysclk) begin
		if (clk_en) begin
			if (fall && (state == idle || (state == receive && bit_cnt < 4'd11)))
				rx_shift <= {dat_sync[1], rx_shift[10:1]}; // Device sends least significant bit first
			if (state == idle && tx.req)
				tx_shift <= {1'b1, ~^tx.data, tx.data}; // Stop, odd parity, then data
			else if (fall && (state == request || state == send))
				tx_shift <= {1'b0, tx_shift[9:1]};
		end
	end

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			state <= idle;
			ps2clk_low <= 1'b0;
			ps2dat_low <= 1'b0;
			rx <= '0;
			timeout <= 1'b0;
			bit_cnt <= '0;
			timer <= '0;
		end else if (clk_en) begin
			rx.strobe <= 1'b0; // Strobe and timeout last one enabled cycle
			timeout <= 1'b0;
			case (state)
				idle: begin
					if (tx.req) begin
						state <= inhibit; // Host request wins over a start bit in the same cycle
						ps2clk_low <= 1'b1;
						timer <= '0;
					end else if (fall) begin
						state <= receive; // That edge clocked in the start bit
						bit_cnt <= 4'd1;
						timer <= '0;
					end else if (!timeout_arm) begin
						timer <= '0;
					end else if (timer == TIMER_BITS'(TIMEOUT_CYCLES - 1)) begin
						timer <= '0;
						timeout <= 1'b1; // No reply for the whole window
					end else begin
						timer <= timer + 1'b1;
					end
				end
				receive: begin
					if (bit_cnt < 4'd11) begin
						if (fall)
							bit_cnt <= bit_cnt + 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 1'b1; // Two settling cycles then the strobe
						if (bit_cnt == 4'd12) begin
							rx.strobe <= frame_ok;
							rx.data <= rx_shift[8:1];
						end
						if (bit_cnt == 4'd13)
							state <= idle;
					end
				end
				inhibit: begin
					timer <= timer + 1'b1;
					if (timer == TIMER_BITS'(INHIBIT_CYCLES - 1)) begin
						state <= request;
						ps2dat_low <= 1'b1; // Start bit goes out while the clock is still held
					end
				end
				request: begin
					ps2clk_low <= 1'b0; // Hand the clock back to the device
					if (fall) begin
						state <= send;
						ps2dat_low <= ~tx_shift[0]; // First data bit
						bit_cnt <= 4'd1;
					end
				end
				send: begin
					if (fall) begin
						ps2dat_low <= ~tx_shift[0]; // Stop bit releases the line
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 4'd9)
							state <= ack;
					end
				end
				ack: begin
					if (fall) begin
						state <= idle;
						timeout <= dat_sync[1]; // Missing acknowledge counts as no reply
						timer <= '0;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// The strobe only comes out of a frame that is still being closed
	a_strobe_in_receive: assert property (@(posedge sysclk) disable iff (reset)
		rx.strobe |-> state == receive);

	// The protocol block only asks to send while the link is free
	a_req_when_idle: assert property (@(posedge sysclk) disable iff (reset)
		clk_en && tx.req |-> state == idle);

endmodule

`default_nettype wire

// ==== source/mouse_pkg.sv ====
`default_nettype none

package mouse_pkg;

	// Protocol walk from power-on through streaming packets
	typedef enum logic [2:0] {
		init,  // Waiting for the self-test result
		id,    // Waiting for the device ID
		setup, // Waiting for the acknowledge of enable reporting
		byte0, // Waiting for the status byte of a packet
		byte1, // Waiting for the X movement byte
		byte2  // Waiting for the Y movement byte
	} mouse_state_e;

	// Byte 0 of a movement packet, most significant bit first
	typedef struct packed {
		logic y_ovr;      // Y overflow
		logic x_ovr;      // X overflow
		logic y_sign;     // Ninth bit of the Y delta
		logic x_sign;     // Ninth bit of the X delta
		logic always_one; // Set in every valid status byte and used to realign
		logic mid;        // Middle button
		logic right;      // Right button
		logic left;       // Left button, high when pressed
	} mouse_status_t;

	// Movement handed to one axis accumulator
	typedef struct packed {
		logic       load;  // One cycle strobe to add the delta
		logic       sign;  // Sign of the nine-bit delta
		logic [7:0] delta; // Low eight bits of the delta
	} axis_move_t;

endpackage

`default_nettype wire

// ==== source/ps2_link_pkg.sv ====
`default_nettype none

package ps2_link_pkg;

	// One good received byte, held for a single enabled cycle
	typedef struct packed {
		logic       strobe; // High for one cycle when a frame passes all checks
		logic [7:0] data;   // Frame payload, least significant bit first on the wire
	} ps2_rx_t;

	// Request to send one byte to the device
	typedef struct packed {
		logic       req;  // One cycle request, dropped if the link is busy
		logic [7:0] data; // Byte to transmit
	} ps2_tx_t;

	// Bit-level link states
	typedef enum logic [2:0] {idle, receive, inhibit, request, send, ack} link_state_e;

	localparam logic [7:0] CMD_RESET       = 8'hff; // Reset and run self-test
	localparam logic [7:0] CMD_ENABLE      = 8'hf4; // Enable data reporting
	localparam logic [7:0] REPLY_ACK       = 8'hfa; // Command acknowledge
	localparam logic [7:0] REPLY_BAT_OK    = 8'haa; // Self-test passed
	localparam logic [7:0] DEVICE_ID_MOUSE = 8'h00; // Standard mouse ID

endpackage

`default_nettype wire
